//--- Bender.yml
package:
  name: tag_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/capi_pkg.sv
      - hw/tag_fifo.sv
      - hw/tag_ram.sv
      - hw/tag_control.sv
      - hw/command_issuer.sv
      - hw/response_router.sv
      - hw/tag_subsystem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tag_subsystem_properties.sv
      - verification/tag_subsystem_tb.sv

//--- hw/capi_pkg.sv
`include "capi_consts.svh"

package capi_pkg;

	// plain vectors with a meaning on the link
	typedef logic [`CAPI_TAG_WIDTH-1:0] tag_t;
	typedef logic [`CAPI_CU_ID_WIDTH-1:0] cu_id_t;
	typedef logic [`CAPI_CMD_TYPE_WIDTH-1:0] cmd_type_t;
	typedef logic [`CAPI_ADDRESS_WIDTH-1:0] address_t;
	typedef logic [`CAPI_RESPONSE_WIDTH-1:0] response_code_t;

	// what the tag ram keeps per tag
	typedef struct packed {
		cu_id_t cu_id;
		cmd_type_t cmd_type;
	} command_tag_line_t;

	// request as it comes in from a compute unit
	typedef struct packed {
		cu_id_t cu_id;
		cmd_type_t cmd_type;
		address_t address;
	} command_request_t;

	// tagged command toward the link
	typedef struct packed {
		tag_t tag;
		cmd_type_t cmd_type;
		address_t address;
	} command_out_t;

	// response routed back to its compute unit
	typedef struct packed {
		cu_id_t cu_id;
		cmd_type_t cmd_type;
		response_code_t response;
	} cu_response_t;

	// tag fifo flags, valid and empty are complements
	typedef struct packed {
		logic full;
		logic alfull;
		logic valid;
		logic empty;
	} tag_buffer_status_t;

	// pool init sequence
	typedef enum logic [1:0] {
		TAG_BUFFER_RESET,
		TAG_BUFFER_INIT,
		TAG_BUFFER_READY
	} tag_buffer_state_e;

endpackage

//--- hw/command_issuer.sv
`timescale 1ns/10ps

module command_issuer (
	input logic clock,
	input logic rstn,
	input logic command_request_valid,
	input capi_pkg::command_request_t command_request,
	output logic command_request_stall,
	input capi_pkg::tag_t tag_head,
	input capi_pkg::tag_buffer_status_t tag_buffer,
	input logic tag_buffer_ready,
	output logic tag_pop,
	output logic tag_record_valid,
	output capi_pkg::tag_t tag_record_tag,
	output capi_pkg::command_tag_line_t tag_record_line,
	output logic command_out_valid,
	output capi_pkg::command_out_t command_out
);

	logic accept;

	// stall while the pool fills or when no tag is left
	assign command_request_stall = !tag_buffer_ready || !tag_buffer.valid;

	// a strobe is taken only while not stalled
	assign accept = command_request_valid && !command_request_stall;

	//////////////////////////////////////////////////////////////////////
	// take the head tag and record its owner
	//////////////////////////////////////////////////////////////////////
	assign tag_pop = accept;
	assign tag_record_valid = accept;
	assign tag_record_tag = tag_head;
	assign tag_record_line.cu_id = command_request.cu_id;
	assign tag_record_line.cmd_type = command_request.cmd_type;

	//////////////////////////////////////////////////////////////////////
	// tagged command toward the link, one cycle after accept
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_out_valid <= 1'b0;
		end else begin
			command_out_valid <= accept;
		end
	end

	// payload only moves on an accepted request
	always_ff @(posedge clock) begin
		if (accept) begin
			command_out.tag <= tag_head;
			command_out.cmd_type <= command_request.cmd_type;
			command_out.address <= command_request.address;
		end
	end

endmodule

//--- hw/response_router.sv
`timescale 1ns/10ps

module response_router (
	input logic clock,
	input logic rstn,
	input logic response_valid,
	input capi_pkg::tag_t response_tag,
	input capi_pkg::response_code_t response_code,
	input logic data_read_valid,
	input capi_pkg::tag_t data_read_tag,
	input capi_pkg::command_tag_line_t response_line,
	input capi_pkg::command_tag_line_t data_read_line,
	output logic cu_response_valid,
	output capi_pkg::cu_response_t cu_response,
	output logic data_read_cu_valid,
	output capi_pkg::command_tag_line_t data_read_cu,
	output logic tag_return_valid,
	output capi_pkg::tag_t tag_return_tag
);

	logic response_valid_q;
	logic data_read_valid_q;
	capi_pkg::tag_t response_tag_q;
	capi_pkg::response_code_t response_code_q;

	//////////////////////////////////////////////////////////////////////
	// line up strobes with the tag ram read
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_valid_q <= 1'b0;
			data_read_valid_q <= 1'b0;
		end else begin
			response_valid_q <= response_valid;
			data_read_valid_q <= data_read_valid;
		end
	end

	always_ff @(posedge clock) begin
		response_tag_q <= response_tag;
		response_code_q <= response_code;
	end

	// response goes to the cu that owns the tag
	// response code passes through as received
	assign cu_response_valid = response_valid_q;
	assign cu_response.cu_id = response_line.cu_id;
	assign cu_response.cmd_type = response_line.cmd_type;
	assign cu_response.response = response_code_q;

	// read beat resolves to its cu, no buffering here
	assign data_read_cu_valid = data_read_valid_q;
	assign data_read_cu = data_read_line;

	// tag is free once its response is routed
	assign tag_return_valid = response_valid_q;
	assign tag_return_tag = response_tag_q;

endmodule

//--- hw/tag_control.sv
`timescale 1ns/10ps
`include "capi_consts.svh"

module tag_control (
	input logic clock,
	input logic rstn,
	input logic tag_pop,
	output capi_pkg::tag_t tag_head,
	output capi_pkg::tag_buffer_status_t tag_buffer,
	output logic tag_buffer_ready,
	input logic tag_record_valid,
	input capi_pkg::tag_t tag_record_tag,
	input capi_pkg::command_tag_line_t tag_record_line,
	input logic tag_return_valid,
	input capi_pkg::tag_t tag_return_tag,
	input capi_pkg::tag_t response_tag,
	output capi_pkg::command_tag_line_t response_line,
	input capi_pkg::tag_t data_read_tag,
	output capi_pkg::command_tag_line_t data_read_line
);

	capi_pkg::tag_buffer_state_e state;
	capi_pkg::tag_buffer_state_e next_state;
	capi_pkg::tag_t init_counter;
	capi_pkg::tag_t fifo_data_in;
	logic init_push;
	logic fifo_push;

	//////////////////////////////////////////////////////////////////////
	// pool init state machine
	//////////////////////////////////////////////////////////////////////
	// reset lasts one cycle, init fills the pool, ready is final
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= capi_pkg::TAG_BUFFER_RESET;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			capi_pkg::TAG_BUFFER_RESET: begin
				next_state = capi_pkg::TAG_BUFFER_INIT;
			end
			capi_pkg::TAG_BUFFER_INIT: begin
				// leave init the cycle after the last tag landed
				if (tag_buffer.full) begin
					next_state = capi_pkg::TAG_BUFFER_READY;
				end
			end
			default: begin
				next_state = capi_pkg::TAG_BUFFER_READY;
			end
		endcase
	end

	// one tag per cycle, stops itself once the fifo reports full
	assign init_push = (state == capi_pkg::TAG_BUFFER_INIT) && !tag_buffer.full;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			init_counter <= '0;
		end else if (init_push) begin
			init_counter <= init_counter + 1'b1;
		end
	end

	// pool is usable only after every tag went in
	assign tag_buffer_ready = (state == capi_pkg::TAG_BUFFER_READY);

	//////////////////////////////////////////////////////////////////////
	// fifo push source
	//////////////////////////////////////////////////////////////////////
	// counter while filling, freed tags from the router afterwards
	always_comb begin
		if (state == capi_pkg::TAG_BUFFER_READY) begin
			fifo_push = tag_return_valid;
			fifo_data_in = tag_return_tag;
		end else begin
			fifo_push = init_push;
			fifo_data_in = init_counter;
		end
	end

	// free tags, popped by the issuer in return order
	tag_fifo #(
		.WIDTH(`CAPI_TAG_WIDTH),
		.DEPTH(`CAPI_TAG_COUNT)
	) u_tag_fifo (
		.clock(clock),
		.rstn(rstn),
		.push(fifo_push),
		.data_in(fifo_data_in),
		.pop(tag_pop),
		.data_out(tag_head),
		.status(tag_buffer)
	);

	// tag to cu bookkeeping, written at the tag actually issued
	tag_ram #(
		.DEPTH(`CAPI_TAG_COUNT)
	) u_tag_ram (
		.clock(clock),
		.write(tag_record_valid),
		.write_addr(tag_record_tag),
		.write_line(tag_record_line),
		.read_addr_a(response_tag),
		.read_line_a(response_line),
		.read_addr_b(data_read_tag),
		.read_line_b(data_read_line)
	);

endmodule

//--- hw/tag_fifo.sv
`timescale 1ns/10ps
`include "capi_consts.svh"

module tag_fifo #(
	parameter int unsigned WIDTH = `CAPI_TAG_WIDTH,
	parameter int unsigned DEPTH = `CAPI_TAG_COUNT
) (
	input logic clock,
	input logic rstn,
	input logic push,
	input logic [WIDTH-1:0] data_in,
	input logic pop,
	output logic [WIDTH-1:0] data_out,
	output capi_pkg::tag_buffer_status_t status
);

	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int unsigned COUNT_W = $clog2(DEPTH + 1);
	localparam int unsigned ALFULL_LEVEL = DEPTH - `CAPI_ALFULL_MARGIN;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [COUNT_W-1:0] count;
	logic push_ok;
	logic pop_ok;

	// drop a push into a full fifo and a pop from an empty one
	assign push_ok = push && !status.full;
	assign pop_ok = pop && status.valid;

	//////////////////////////////////////////////////////////////////////
	// storage, no reset on the entries
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (push_ok) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// head is visible without a read cycle
	assign data_out = mem[rd_ptr];

	//////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok) begin
				// wrap at the last entry, depth need not be a power of two
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// push and pop together leave the count alone
			if (push_ok && !pop_ok) begin
				count <= count + 1'b1;
			end else if (pop_ok && !push_ok) begin
				count <= count - 1'b1;
			end
		end
	end

	// flags straight from the occupancy counter
	assign status.full = (count == COUNT_W'(DEPTH));
	assign status.alfull = (count >= COUNT_W'(ALFULL_LEVEL));
	assign status.valid = (count != '0);
	assign status.empty = (count == '0);

endmodule

//--- hw/tag_ram.sv
`timescale 1ns/10ps
`include "capi_consts.svh"

module tag_ram #(
	parameter int unsigned DEPTH = `CAPI_TAG_COUNT
) (
	input logic clock,
	input logic write,
	input capi_pkg::tag_t write_addr,
	input capi_pkg::command_tag_line_t write_line,
	input capi_pkg::tag_t read_addr_a,
	output capi_pkg::command_tag_line_t read_line_a,
	input capi_pkg::tag_t read_addr_b,
	output capi_pkg::command_tag_line_t read_line_b
);

	// one line per tag: owning cu and command type
	capi_pkg::command_tag_line_t mem [DEPTH];

	// single write port, driven by the issuer
	always_ff @(posedge clock) begin
		if (write) begin
			mem[write_addr] <= write_line;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// two registered read ports
	//////////////////////////////////////////////////////////////////////
	// port a serves response lookups
	// port b serves read data beats
	// both are ready one cycle after the address
	always_ff @(posedge clock) begin
		read_line_a <= mem[read_addr_a];
		read_line_b <= mem[read_addr_b];
	end

endmodule

//--- hw/tag_subsystem_top.sv
`timescale 1ns/10ps

module tag_subsystem_top (
	input logic clock,
	input logic rstn,
	input logic command_request_valid,
	input capi_pkg::command_request_t command_request,
	output logic command_request_stall,
	output logic command_out_valid,
	output capi_pkg::command_out_t command_out,
	input logic response_valid,
	input capi_pkg::tag_t response_tag,
	input capi_pkg::response_code_t response_code,
	input logic data_read_valid,
	input capi_pkg::tag_t data_read_tag,
	output logic cu_response_valid,
	output capi_pkg::cu_response_t cu_response,
	output logic data_read_cu_valid,
	output capi_pkg::command_tag_line_t data_read_cu
);

	// issuer to tag control
	capi_pkg::tag_t tag_head;
	capi_pkg::tag_buffer_status_t tag_buffer;
	logic tag_buffer_ready;
	logic tag_pop;
	logic tag_record_valid;
	capi_pkg::tag_t tag_record_tag;
	capi_pkg::command_tag_line_t tag_record_line;

	// router to tag control
	capi_pkg::command_tag_line_t response_line;
	capi_pkg::command_tag_line_t data_read_line;
	logic tag_return_valid;
	capi_pkg::tag_t tag_return_tag;

	//////////////////////////////////////////////////////////////////////
	// producer side
	//////////////////////////////////////////////////////////////////////
	command_issuer u_command_issuer (
		.clock(clock),
		.rstn(rstn),
		.command_request_valid(command_request_valid),
		.command_request(command_request),
		.command_request_stall(command_request_stall),
		.tag_head(tag_head),
		.tag_buffer(tag_buffer),
		.tag_buffer_ready(tag_buffer_ready),
		.tag_pop(tag_pop),
		.tag_record_valid(tag_record_valid),
		.tag_record_tag(tag_record_tag),
		.tag_record_line(tag_record_line),
		.command_out_valid(command_out_valid),
		.command_out(command_out)
	);

	//////////////////////////////////////////////////////////////////////
	// tag pool and bookkeeping
	//////////////////////////////////////////////////////////////////////
	// lookup addresses come straight from the link side
	tag_control u_tag_control (
		.clock(clock),
		.rstn(rstn),
		.tag_pop(tag_pop),
		.tag_head(tag_head),
		.tag_buffer(tag_buffer),
		.tag_buffer_ready(tag_buffer_ready),
		.tag_record_valid(tag_record_valid),
		.tag_record_tag(tag_record_tag),
		.tag_record_line(tag_record_line),
		.tag_return_valid(tag_return_valid),
		.tag_return_tag(tag_return_tag),
		.response_tag(response_tag),
		.response_line(response_line),
		.data_read_tag(data_read_tag),
		.data_read_line(data_read_line)
	);

	//////////////////////////////////////////////////////////////////////
	// consumer side
	//////////////////////////////////////////////////////////////////////
	response_router u_response_router (
		.clock(clock),
		.rstn(rstn),
		.response_valid(response_valid),
		.response_tag(response_tag),
		.response_code(response_code),
		.data_read_valid(data_read_valid),
		.data_read_tag(data_read_tag),
		.response_line(response_line),
		.data_read_line(data_read_line),
		.cu_response_valid(cu_response_valid),
		.cu_response(cu_response),
		.data_read_cu_valid(data_read_cu_valid),
		.data_read_cu(data_read_cu),
		.tag_return_valid(tag_return_valid),
		.tag_return_tag(tag_return_tag)
	);

endmodule

//--- include/capi_consts.svh
`ifndef CAPI_CONSTS_SVH
`define CAPI_CONSTS_SVH

// tag pool geometry
// one tag per outstanding command on the link
`define CAPI_TAG_WIDTH 8
`define CAPI_TAG_COUNT 256

// compute unit index and link command code
`define CAPI_CU_ID_WIDTH 4
`define CAPI_CMD_TYPE_WIDTH 13

// effective address carried with each command
`define CAPI_ADDRESS_WIDTH 64

// link response code, passed through untouched
`define CAPI_RESPONSE_WIDTH 8

// almost full fires this many entries below full
`define CAPI_ALFULL_MARGIN 4

`endif

//--- project.f
+incdir+include
hw/capi_pkg.sv
hw/tag_fifo.sv
hw/tag_ram.sv
hw/tag_control.sv
hw/command_issuer.sv
hw/response_router.sv
hw/tag_subsystem_top.sv
verification/tag_subsystem_properties.sv
verification/tag_subsystem_tb.sv

//--- verification/tag_subsystem_properties.sv
`timescale 1ns/10ps

module tag_subsystem_properties (
	input logic clock,
	input logic rstn,
	input logic fifo_push,
	input logic fifo_pop,
	input logic fifo_full,
	input logic fifo_empty,
	input logic command_out_valid,
	input logic tag_buffer_ready,
	input logic command_request_valid,
	input logic command_request_stall
);

	// number of fired assertions, read by the testbench
	int unsigned failures = 0;

	//////////////////////////////////////////////////////////////////////
	// tag fifo occupancy
	//////////////////////////////////////////////////////////////////////
	// pool never takes more tags than it has room for
	property no_push_when_full;
		@(posedge clock) disable iff (!rstn) fifo_push |-> !fifo_full;
	endproperty

	// issuer never pops a tag that is not there
	property no_pop_when_empty;
		@(posedge clock) disable iff (!rstn) fifo_pop |-> !fifo_empty;
	endproperty

	//////////////////////////////////////////////////////////////////////
	// issue side protocol
	//////////////////////////////////////////////////////////////////////
	// nothing leaves for the link while the pool is still filling
	property no_command_before_ready;
		@(posedge clock) disable iff (!rstn) command_out_valid |-> tag_buffer_ready;
	endproperty

	// requester must hold off while stalled
	property no_request_while_stalled;
		@(posedge clock) disable iff (!rstn) command_request_valid |-> !command_request_stall;
	endproperty

	assert property (no_push_when_full) else begin
		$error("tag pushed into a full FIFO");
		failures++;
	end

	assert property (no_pop_when_empty) else begin
		$error("tag popped from an empty FIFO");
		failures++;
	end

	assert property (no_command_before_ready) else begin
		$error("command issued before the tag pool was ready");
		failures++;
	end

	assert property (no_request_while_stalled) else begin
		$error("request strobe seen while the issuer stalls");
		failures++;
	end

endmodule

// fifo side checks on the pool
bind tag_control tag_subsystem_properties u_tag_control_properties (
	.clock(clock),
	.rstn(rstn),
	.fifo_push(fifo_push),
	.fifo_pop(tag_pop),
	.fifo_full(tag_buffer.full),
	.fifo_empty(tag_buffer.empty),
	.command_out_valid(1'b0),
	.tag_buffer_ready(tag_buffer_ready),
	.command_request_valid(1'b0),
	.command_request_stall(1'b0)
);

// issue side checks
bind command_issuer tag_subsystem_properties u_command_issuer_properties (
	.clock(clock),
	.rstn(rstn),
	.fifo_push(1'b0),
	.fifo_pop(tag_pop),
	.fifo_full(1'b0),
	.fifo_empty(tag_buffer.empty),
	.command_out_valid(command_out_valid),
	.tag_buffer_ready(tag_buffer_ready),
	.command_request_valid(command_request_valid),
	.command_request_stall(command_request_stall)
);

//--- verification/tag_subsystem_tb.sv
`timescale 1ns/10ps
`include "capi_consts.svh"

module tag_subsystem_tb;

	localparam int READY_TIMEOUT = 400;
	localparam int WAIT_TIMEOUT = 50;
	localparam int MIX_CYCLES = 2000;

	logic clock;
	logic rstn;
	logic command_request_valid;
	capi_pkg::command_request_t command_request;
	logic command_request_stall;
	logic command_out_valid;
	capi_pkg::command_out_t command_out;
	logic response_valid;
	capi_pkg::tag_t response_tag;
	capi_pkg::response_code_t response_code;
	logic data_read_valid;
	capi_pkg::tag_t data_read_tag;
	logic cu_response_valid;
	capi_pkg::cu_response_t cu_response;
	logic data_read_cu_valid;
	capi_pkg::command_tag_line_t data_read_cu;

	// reference model of the free pool and the issued tags
	capi_pkg::tag_t tag_pool [$];
	capi_pkg::tag_t outstanding [$];
	capi_pkg::command_request_t request_by_tag [`CAPI_TAG_COUNT];

	// expected output strobes and the cycle each one is due
	capi_pkg::command_out_t exp_command [$];
	int exp_command_due [$];
	capi_pkg::cu_response_t exp_response [$];
	int exp_response_due [$];
	capi_pkg::command_tag_line_t exp_line [$];
	int exp_line_due [$];

	int cycle;
	string test_name;

	tag_subsystem_top u_tag_subsystem_top (
		.clock(clock),
		.rstn(rstn),
		.command_request_valid(command_request_valid),
		.command_request(command_request),
		.command_request_stall(command_request_stall),
		.command_out_valid(command_out_valid),
		.command_out(command_out),
		.response_valid(response_valid),
		.response_tag(response_tag),
		.response_code(response_code),
		.data_read_valid(data_read_valid),
		.data_read_tag(data_read_tag),
		.cu_response_valid(cu_response_valid),
		.cu_response(cu_response),
		.data_read_cu_valid(data_read_cu_valid),
		.data_read_cu(data_read_cu)
	);

	// 4 ns period
	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////
	// next tag the issuer must hand out, pool order is return order
	function automatic capi_pkg::tag_t take_expected_tag();
		return tag_pool.pop_front();
	endfunction

	// owner line recorded when the tag went out
	function automatic capi_pkg::command_tag_line_t expected_line(input capi_pkg::tag_t tag);
		capi_pkg::command_tag_line_t line;
		line.cu_id = request_by_tag[tag].cu_id;
		line.cmd_type = request_by_tag[tag].cmd_type;
		return line;
	endfunction

	// routed response carries the owner and the untouched code
	function automatic capi_pkg::cu_response_t expected_response(input capi_pkg::tag_t tag,
			input capi_pkg::response_code_t code);
		capi_pkg::cu_response_t resp;
		resp.cu_id = request_by_tag[tag].cu_id;
		resp.cmd_type = request_by_tag[tag].cmd_type;
		resp.response = code;
		return resp;
	endfunction

	function automatic capi_pkg::command_request_t random_request();
		capi_pkg::command_request_t req;
		req.cu_id = capi_pkg::cu_id_t'($urandom);
		req.cmd_type = capi_pkg::cmd_type_t'($urandom);
		req.address = {$urandom, $urandom};
		return req;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////
	task automatic check_command(input capi_pkg::command_out_t expected,
			input capi_pkg::command_out_t actual);
		if (actual !== expected) begin
			stop_run($sformatf("FAIL %s command_out expected %h actual %h",
				test_name, expected, actual));
		end
	endtask

	task automatic check_cu_response(input capi_pkg::cu_response_t expected,
			input capi_pkg::cu_response_t actual);
		if (actual !== expected) begin
			stop_run($sformatf("FAIL %s cu_response expected %h actual %h",
				test_name, expected, actual));
		end
	endtask

	task automatic check_line(input capi_pkg::command_tag_line_t expected,
			input capi_pkg::command_tag_line_t actual);
		if (actual !== expected) begin
			stop_run($sformatf("FAIL %s data_read_cu expected %h actual %h",
				test_name, expected, actual));
		end
	endtask

	// outputs are sampled mid cycle where they are stable
	always @(negedge clock) begin
		if (u_tag_subsystem_top.u_tag_control.u_tag_control_properties.failures != 0 ||
				u_tag_subsystem_top.u_command_issuer.u_command_issuer_properties.failures != 0) begin
			stop_run("a bound assertion on the tag pool or the issuer fired");
		end
		if (exp_command_due.size() != 0 && exp_command_due[0] == cycle) begin
			if (!command_out_valid) begin
				stop_run({"command_out_valid did not rise one cycle after the request in ",
					test_name});
			end
			check_command(exp_command.pop_front(), command_out);
			void'(exp_command_due.pop_front());
		end else if (command_out_valid) begin
			stop_run({"command_out_valid rose with no request behind it in ", test_name});
		end
		if (exp_response_due.size() != 0 && exp_response_due[0] == cycle) begin
			if (!cu_response_valid) begin
				stop_run({"cu_response_valid did not rise one cycle after the response in ",
					test_name});
			end
			check_cu_response(exp_response.pop_front(), cu_response);
			void'(exp_response_due.pop_front());
		end else if (cu_response_valid) begin
			stop_run({"cu_response_valid rose with no response behind it in ", test_name});
		end
		if (exp_line_due.size() != 0 && exp_line_due[0] == cycle) begin
			if (!data_read_cu_valid) begin
				stop_run({"data_read_cu_valid did not rise one cycle after the lookup in ",
					test_name});
			end
			check_line(exp_line.pop_front(), data_read_cu);
			void'(exp_line_due.pop_front());
		end else if (data_read_cu_valid) begin
			stop_run({"data_read_cu_valid rose with no lookup behind it in ", test_name});
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////
	// strobes last one cycle and change 1 ns after the edge
	task automatic begin_cycle();
		@(posedge clock);
		#1;
		command_request_valid = 1'b0;
		response_valid = 1'b0;
		data_read_valid = 1'b0;
	endtask

	task automatic drive_request(input capi_pkg::command_request_t req);
		capi_pkg::tag_t tag;
		capi_pkg::command_out_t cmd;
		if (command_request_stall) begin
			stop_run({"request driven while the issuer stalls in ", test_name});
		end
		if (tag_pool.size() == 0) begin
			stop_run({"issuer ready although the model pool is empty in ", test_name});
		end
		tag = take_expected_tag();
		cmd.tag = tag;
		cmd.cmd_type = req.cmd_type;
		cmd.address = req.address;
		request_by_tag[tag] = req;
		outstanding.push_back(tag);
		exp_command.push_back(cmd);
		exp_command_due.push_back(cycle + 1);
		command_request_valid = 1'b1;
		command_request = req;
	endtask

	task automatic drive_response(input int index);
		capi_pkg::tag_t tag;
		capi_pkg::response_code_t code;
		tag = outstanding[index];
		outstanding.delete(index);
		code = capi_pkg::response_code_t'($urandom);
		exp_response.push_back(expected_response(tag, code));
		exp_response_due.push_back(cycle + 1);
		// freed tag goes to the back of the pool
		tag_pool.push_back(tag);
		response_valid = 1'b1;
		response_tag = tag;
		response_code = code;
	endtask

	task automatic drive_data_read(input int index);
		capi_pkg::tag_t tag;
		tag = outstanding[index];
		exp_line.push_back(expected_line(tag));
		exp_line_due.push_back(cycle + 1);
		data_read_valid = 1'b1;
		data_read_tag = tag;
	endtask

	task automatic wait_not_stalled(input int limit);
		int waited;
		waited = 0;
		while (command_request_stall) begin
			if (waited == limit) begin
				stop_run({"stall stayed high with tags back in the pool in ", test_name});
			end
			begin_cycle();
			waited++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		int waited;
		void'($urandom(32'h2beed396));
		clock = 1'b0;
		rstn = 1'b0;
		cycle = 0;
		command_request_valid = 1'b0;
		command_request = '0;
		response_valid = 1'b0;
		response_tag = '0;
		response_code = '0;
		data_read_valid = 1'b0;
		data_read_tag = '0;
		for (int t = 0; t < `CAPI_TAG_COUNT; t++) begin
			tag_pool.push_back(capi_pkg::tag_t'(t));
		end

		// stall holds through the whole pool fill
		test_name = "init_stall";
		repeat (2) @(posedge clock);
		#1;
		rstn = 1'b1;
		waited = 0;
		while (command_request_stall) begin
			if (waited == READY_TIMEOUT) begin
				stop_run("stall never fell after reset, pool init did not finish");
			end
			begin_cycle();
			waited++;
		end
		if (waited < `CAPI_TAG_COUNT) begin
			stop_run("stall fell before every tag was pushed into the pool");
		end

		// back to back, tags 0 to 255 in order
		test_name = "first_pass_tags";
		for (int i = 0; i < `CAPI_TAG_COUNT; i++) begin
			drive_request(random_request());
			begin_cycle();
		end

		// empty pool, one response frees exactly one tag
		test_name = "pool_exhausted";
		if (!command_request_stall) begin
			stop_run("stall low with every tag outstanding");
		end
		drive_response($urandom_range(outstanding.size() - 1));
		begin_cycle();
		wait_not_stalled(WAIT_TIMEOUT);
		// only the freed tag is in the model pool
		drive_request(random_request());

		// out of order returns, reissue follows return order
		test_name = "random_order_responses";
		begin_cycle();
		for (int i = 0; i < 64; i++) begin
			drive_response($urandom_range(outstanding.size() - 1));
			begin_cycle();
		end
		for (int i = 0; i < 64; i++) begin
			wait_not_stalled(WAIT_TIMEOUT);
			drive_request(random_request());
			begin_cycle();
		end

		test_name = "data_read_lookup";
		for (int i = 0; i < 32; i++) begin
			drive_data_read($urandom_range(outstanding.size() - 1));
			begin_cycle();
		end

		// response first, then lookup on what is left, then a new request
		// a lookup never targets a tag issued in the same cycle
		test_name = "random_mix";
		for (int i = 0; i < MIX_CYCLES; i++) begin
			if (outstanding.size() != 0 && $urandom_range(1) == 0) begin
				drive_response($urandom_range(outstanding.size() - 1));
			end
			if (outstanding.size() != 0 && $urandom_range(3) == 0) begin
				drive_data_read($urandom_range(outstanding.size() - 1));
			end
			if (!command_request_stall && $urandom_range(1) == 0) begin
				drive_request(random_request());
			end
			begin_cycle();
		end

		// let the last strobes come out
		test_name = "drain";
		waited = 0;
		while ((exp_command.size() != 0 || exp_response.size() != 0 ||
				exp_line.size() != 0) && waited < WAIT_TIMEOUT) begin
			begin_cycle();
			waited++;
		end
		if (exp_command.size() == 0 && exp_response.size() == 0 && exp_line.size() == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			stop_run("expected output strobes still pending after the drain timeout");
		end
	end

endmodule
